// ==== common/isa_pkg.sv ====
package isa_pkg;

    // Architectural widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int CSR_AW = 14;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_CSRRD,
        OP_CSRWR
    } op_e;

    // CSR instructions carry the CSR number in the low immediate bits
    typedef struct packed {
        logic [XLEN-CSR_AW-1:0] unused;
        logic [CSR_AW-1:0]      csr_addr;
    } csr_view_t;

    typedef union packed {
        logic [XLEN-1:0] value;
        csr_view_t       csr;
    } imm_u;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // One queued instruction, also the form dispatch sees at the queue head
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic              use_imm;
        imm_u              imm;
    } slot_t;

    // Operation with resolved operands, handed to execute
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   opnd1;
        logic [XLEN-1:0]   opnd2;
        logic [CSR_AW-1:0] csr_addr;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } fwd_t;

endpackage

// ==== common/slot_if.sv ====
`timescale 1ns/1ps

interface slot_if
    import pipe_pkg::*;
();

    // Two oldest queue entries
    slot_t      head0;
    slot_t      head1;
    // Number of entries dispatch consumes this cycle
    logic [1:0] take;

    modport producer (output head0, output head1, input take);

    modport consumer (input head0, input head1, output take);

endinterface

// ==== hw/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue
    import pipe_pkg::*;
#(
    parameter int QDEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [1:0]      in_valid_i,
    input  slot_t [1:0]     in_slot_i,
    output logic            in_ready_o,
    slot_if.producer        q
);

    localparam int PW = $clog2(QDEPTH);
    localparam int CW = $clog2(QDEPTH + 1);

    slot_t         mem [QDEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic [1:0]    n_push;

    // Wrapping add, also correct for depths that are not a power of two
    function automatic logic [PW-1:0] ptr_add(logic [PW-1:0] p, logic [1:0] k);
        logic [PW:0] s;
        s = {1'b0, p} + (PW+1)'(k);
        if (s >= (PW+1)'(QDEPTH)) begin
            s = s - (PW+1)'(QDEPTH);
        end
        return s[PW-1:0];
    endfunction

    // Room for a full pair is required before accepting
    assign in_ready_o = (int'(count) + 2 <= QDEPTH);
    assign push       = in_ready_o && in_valid_i[0];
    assign n_push     = push ? (in_valid_i[1] ? 2'd2 : 2'd1) : 2'd0;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_slot_i[0];
            if (in_valid_i[1]) begin
                mem[ptr_add(wr_ptr, 2'd1)] <= in_slot_i[1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, n_push);
            rd_ptr <= ptr_add(rd_ptr, q.take);
            count  <= count + CW'(n_push) - CW'(q.take);
        end
    end

    // Head valid bits come from the fill level
    always_comb begin
        q.head0       = mem[rd_ptr];
        q.head1       = mem[ptr_add(rd_ptr, 2'd1)];
        q.head0.valid = (count != '0);
        q.head1.valid = (count > CW'(1));
    end

endmodule

// ==== dispatch/regfile.sv ====
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0][REG_AW-1:0] raddr_i,
    output logic [3:0][XLEN-1:0]   rdata_o,
    input  logic [1:0]             we_i,
    input  logic [1:0][REG_AW-1:0] waddr_i,
    input  logic [1:0][XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [32];

    // Port 1 is written last so the younger lane wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && waddr_i[w] != '0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // Same-cycle writes are not bypassed here
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdata_o[k] = (raddr_i[k] == '0) ? '0 : regs[raddr_i[k]];
        end
    end

endmodule

// ==== dispatch/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    slot_if.consumer               q,
    output logic [3:0][REG_AW-1:0] rf_raddr_o,
    input  logic [3:0][XLEN-1:0]   rf_rdata_i,
    input  fwd_t [1:0]             ex_fwd_i,
    input  fwd_t [1:0]             wb_fwd_i,
    output issue_t [1:0]           issue_o
);

    slot_t           hd [2];
    logic [1:0]      take_lane;
    logic            hazard;
    logic            any_csr;
    fwd_t [3:0]      srcs;
    logic [XLEN-1:0] opnd1 [2];
    logic [XLEN-1:0] opnd2 [2];
    issue_t          pl_q [2];

    function automatic logic is_csr(op_e op);
        return (op == OP_CSRRD) || (op == OP_CSRWR);
    endfunction

    // Sources in rising priority with execute lane 1 at index 3
    function automatic logic [XLEN-1:0] resolve(logic [REG_AW-1:0] addr,
                                                logic [XLEN-1:0] rf_val,
                                                fwd_t [3:0] src);
        logic [XLEN-1:0] val;
        val = rf_val;
        for (int k = 0; k < 4; k++) begin
            if (src[k].valid && src[k].addr != '0 && src[k].addr == addr) begin
                val = src[k].data;
            end
        end
        return val;
    endfunction

    assign hd[0] = q.head0;
    assign hd[1] = q.head1;
    assign srcs  = {ex_fwd_i, wb_fwd_i};

    // RAW inside the pair counts rs2 only when no immediate is used
    assign hazard = (hd[0].rd != '0) &&
                    ((hd[1].rs1 == hd[0].rd) ||
                     (!hd[1].use_imm && hd[1].rs2 == hd[0].rd));
    assign any_csr = is_csr(hd[0].op) || is_csr(hd[1].op);

    assign take_lane[0] = hd[0].valid;
    assign take_lane[1] = hd[0].valid && hd[1].valid && !any_csr && !hazard;
    assign q.take       = take_lane[1] ? 2'd2 : (take_lane[0] ? 2'd1 : 2'd0);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_raddr_o[2*i]   = hd[i].rs1;
            rf_raddr_o[2*i+1] = hd[i].rs2;
            opnd1[i] = resolve(hd[i].rs1, rf_rdata_i[2*i], srcs);
            opnd2[i] = hd[i].use_imm ? hd[i].imm.value
                                     : resolve(hd[i].rs2, rf_rdata_i[2*i+1], srcs);
        end
    end

    // Lanes not taken go invalid in the issue register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                pl_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                pl_q[i].valid <= take_lane[i];
                if (take_lane[i]) begin
                    pl_q[i].op       <= hd[i].op;
                    pl_q[i].rd       <= hd[i].rd;
                    pl_q[i].opnd1    <= opnd1[i];
                    pl_q[i].opnd2    <= opnd2[i];
                    pl_q[i].csr_addr <= hd[i].imm.csr.csr_addr;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            issue_o[i] = pl_q[i];
        end
    end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_t [1:0]           issue_i,
    output fwd_t [1:0]             ex_fwd_o,
    output fwd_t [1:0]             wb_fwd_o,
    output logic [1:0]             rf_we_o,
    output logic [1:0][REG_AW-1:0] rf_waddr_o,
    output logic [1:0][XLEN-1:0]   rf_wdata_o,
    output logic [1:0]             wb_valid_o,
    output logic [1:0][REG_AW-1:0] wb_rd_o,
    output logic [1:0][XLEN-1:0]   wb_data_o
);

    logic [XLEN-1:0]   csr_q [4];
    logic              csr_hit;
    logic              csr_we;
    logic [XLEN-1:0]   csr_rdata;
    logic [XLEN-1:0]   result [2];
    logic [1:0]        wb_valid_q;
    logic [REG_AW-1:0] wb_rd_q [2];
    logic [XLEN-1:0]   wb_data_q [2];

    function automatic logic [XLEN-1:0] alu(op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLT:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: r = '0;
        endcase
        return r;
    endfunction

    // Only CSR numbers 0..3 exist
    assign csr_hit   = (issue_i[0].csr_addr[CSR_AW-1:2] == '0);
    assign csr_rdata = csr_hit ? csr_q[issue_i[0].csr_addr[1:0]] : '0;
    assign csr_we    = issue_i[0].valid && issue_i[0].op == OP_CSRWR && csr_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < 4; c++) begin
                csr_q[c] <= '0;
            end
        end else if (csr_we) begin
            csr_q[issue_i[0].csr_addr[1:0]] <= issue_i[0].opnd1;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            result[i] = alu(issue_i[i].op, issue_i[i].opnd1, issue_i[i].opnd2);
        end
        // CSR ops never pair, so only lane 0 sees them
        if (issue_i[0].op == OP_CSRRD || issue_i[0].op == OP_CSRWR) begin
            result[0] = csr_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= '0;
        end else begin
            wb_valid_q <= {issue_i[1].valid, issue_i[0].valid};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            wb_rd_q[i]   <= issue_i[i].rd;
            wb_data_q[i] <= result[i];
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ex_fwd_o[i] = '{valid: issue_i[i].valid, addr: issue_i[i].rd, data: result[i]};
            wb_fwd_o[i] = '{valid: wb_valid_q[i], addr: wb_rd_q[i], data: wb_data_q[i]};
            rf_waddr_o[i] = wb_rd_q[i];
            rf_wdata_o[i] = wb_data_q[i];
            wb_rd_o[i]    = wb_rd_q[i];
            wb_data_o[i]  = wb_data_q[i];
        end
    end

    // rd 0 still retires, the register file drops it
    assign rf_we_o    = wb_valid_q;
    assign wb_valid_o = wb_valid_q;

endmodule

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int QDEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             in_valid_i,
    input  op_e [1:0]              in_op_i,
    input  logic [1:0][REG_AW-1:0] in_rd_i,
    input  logic [1:0][REG_AW-1:0] in_rs1_i,
    input  logic [1:0][REG_AW-1:0] in_rs2_i,
    input  logic [1:0]             in_use_imm_i,
    input  logic [1:0][XLEN-1:0]   in_imm_i,
    output logic                   in_ready_o,
    output logic [1:0]             wb_valid_o,
    output logic [1:0][REG_AW-1:0] wb_rd_o,
    output logic [1:0][XLEN-1:0]   wb_data_o
);

    slot_t [1:0]            in_slot;
    logic [3:0][REG_AW-1:0] rf_raddr;
    logic [3:0][XLEN-1:0]   rf_rdata;
    logic [1:0]             rf_we;
    logic [1:0][REG_AW-1:0] rf_waddr;
    logic [1:0][XLEN-1:0]   rf_wdata;
    fwd_t [1:0]             ex_fwd;
    fwd_t [1:0]             wb_fwd;
    issue_t [1:0]           issue;

    slot_if i_slot ();

    for (genvar i = 0; i < 2; i++) begin : g_in_slot
        assign in_slot[i] = '{valid:   in_valid_i[i],
                              op:      in_op_i[i],
                              rd:      in_rd_i[i],
                              rs1:     in_rs1_i[i],
                              rs2:     in_rs2_i[i],
                              use_imm: in_use_imm_i[i],
                              imm:     in_imm_i[i]};
    end

    instr_queue #(
        .QDEPTH (QDEPTH)
    ) i_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .in_slot_i  (in_slot),
        .in_ready_o (in_ready_o),
        .q          (i_slot.producer)
    );

    regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata)
    );

    dispatch_stage i_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .q          (i_slot.consumer),
        .rf_raddr_o (rf_raddr),
        .rf_rdata_i (rf_rdata),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_fwd),
        .issue_o    (issue)
    );

    exec_unit i_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_i    (issue),
        .ex_fwd_o   (ex_fwd),
        .wb_fwd_o   (wb_fwd),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
    import isa_pkg::*;
#(
    parameter int QDEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             in_valid_i,
    input  op_e [1:0]              in_op_i,
    input  logic [1:0][REG_AW-1:0] in_rd_i,
    input  logic [1:0][REG_AW-1:0] in_rs1_i,
    input  logic [1:0][REG_AW-1:0] in_rs2_i,
    input  logic [1:0]             in_use_imm_i,
    input  logic [1:0][XLEN-1:0]   in_imm_i,
    input  logic                   in_ready_i,
    input  logic [1:0]             wb_valid_i,
    input  logic [1:0][REG_AW-1:0] wb_rd_i,
    input  logic [1:0][XLEN-1:0]   wb_data_i,
    output int                     error_count_o,
    output int                     retired_o
);

    typedef struct packed {
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic              use_imm;
        logic [XLEN-1:0]   data;
    } expect_t;

    logic [XLEN-1:0] model_rf [32];
    logic [XLEN-1:0] model_csr [4];
    expect_t         pending [$];
    int              errors;
    int              accepted;
    int              retired;

    assign error_count_o = errors;
    assign retired_o     = retired;

    // Executes one instruction in program order at acceptance
    task automatic accept_instr(int s);
        expect_t           e;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [CSR_AW-1:0] ca;
        logic              hit;
        a  = (in_rs1_i[s] == '0) ? '0 : model_rf[in_rs1_i[s]];
        b  = (in_rs2_i[s] == '0) ? '0 : model_rf[in_rs2_i[s]];
        b  = in_use_imm_i[s] ? in_imm_i[s] : b;
        ca = in_imm_i[s][CSR_AW-1:0];
        hit = (ca < 14'd4);
        e.op      = in_op_i[s];
        e.rd      = in_rd_i[s];
        e.rs1     = in_rs1_i[s];
        e.rs2     = in_rs2_i[s];
        e.use_imm = in_use_imm_i[s];
        case (in_op_i[s])
            OP_ADD:   e.data = a + b;
            OP_SUB:   e.data = a - b;
            OP_AND:   e.data = a & b;
            OP_OR:    e.data = a | b;
            OP_XOR:   e.data = a ^ b;
            OP_SLT:   e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_CSRRD: e.data = hit ? model_csr[ca[1:0]] : '0;
            OP_CSRWR: begin
                e.data = hit ? model_csr[ca[1:0]] : '0;
                if (hit) begin
                    model_csr[ca[1:0]] = a;
                end
            end
            default:  e.data = '0;
        endcase
        if (in_rd_i[s] != '0) begin
            model_rf[in_rd_i[s]] = e.data;
        end
        pending.push_back(e);
        accepted++;
    endtask

    // Two oldest outstanding entries form the pair on the wb lanes
    task automatic check_pair();
        expect_t older;
        expect_t younger;
        older   = pending[0];
        younger = pending[1];
        if (older.op == OP_CSRRD || older.op == OP_CSRWR ||
            younger.op == OP_CSRRD || younger.op == OP_CSRWR) begin
            errors++;
            $display("pairing error at %0t: a CSR operation retired together with another",
                     $time);
        end
        if (older.rd != '0 && (younger.rs1 == older.rd ||
                               (!younger.use_imm && younger.rs2 == older.rd))) begin
            errors++;
            $display("pairing error at %0t: lane 1 reads x%0d written by lane 0",
                     $time, older.rd);
        end
    endtask

    task automatic retire_lane(int lane);
        expect_t e;
        if (pending.size() == 0) begin
            errors++;
            $display("unexpected writeback on lane %0d at %0t with nothing outstanding",
                     lane, $time);
        end else begin
            e = pending.pop_front();
            retired++;
            if (wb_rd_i[lane] !== e.rd) begin
                errors++;
                $display("mismatch at %0t: wb_rd_o[%0d] = %0d, expected %0d",
                         $time, lane, wb_rd_i[lane], e.rd);
            end
            if (wb_data_i[lane] !== e.data) begin
                errors++;
                $display("mismatch at %0t: wb_data_o[%0d] = %h, expected %h",
                         $time, lane, wb_data_i[lane], e.data);
            end
        end
    endtask

    // Queue holds the outstanding entries minus at most one pair in issue
    task automatic check_ready();
        int outstanding;
        outstanding = accepted - retired;
        if (!in_ready_i && outstanding < QDEPTH - 1) begin
            errors++;
            $display("in_ready_o low at %0t with only %0d instructions outstanding",
                     $time, outstanding);
        end
        if (in_ready_i && outstanding > QDEPTH) begin
            errors++;
            $display("in_ready_o high at %0t with %0d instructions outstanding",
                     $time, outstanding);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                model_rf[r] = '0;
            end
            for (int c = 0; c < 4; c++) begin
                model_csr[c] = '0;
            end
            pending.delete();
            errors   = 0;
            accepted = 0;
            retired  = 0;
        end else begin
            if (accepted == 0 && wb_valid_i != 2'b00) begin
                errors++;
                $display("wb_valid_o set at %0t after reset before any input", $time);
            end
            if (wb_valid_i == 2'b11 && pending.size() >= 2) begin
                check_pair();
            end
            // Lane 0 always holds the older instruction
            for (int lane = 0; lane < 2; lane++) begin
                if (wb_valid_i[lane]) begin
                    retire_lane(lane);
                end
            end
            check_ready();
            if (in_ready_i && in_valid_i[0]) begin
                accept_instr(0);
                if (in_valid_i[1]) begin
                    accept_instr(1);
                end
            end
        end
    end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import isa_pkg::*;
();

    localparam int QDEPTH      = 4;
    localparam int N_INSTR     = 400;
    localparam int STIM_LIMIT  = 4000;
    localparam int DRAIN_LIMIT = 200;

    logic                   clk;
    logic                   rst_n;
    logic [1:0]             in_valid;
    op_e [1:0]              in_op;
    logic [1:0][REG_AW-1:0] in_rd;
    logic [1:0][REG_AW-1:0] in_rs1;
    logic [1:0][REG_AW-1:0] in_rs2;
    logic [1:0]             in_use_imm;
    logic [1:0][XLEN-1:0]   in_imm;
    logic                   in_ready;
    logic [1:0]             wb_valid;
    logic [1:0][REG_AW-1:0] wb_rd;
    logic [1:0][XLEN-1:0]   wb_data;

    integer seed;
    int     accepted;
    int     cycles;
    int     tb_errors;
    int     chk_errors;
    int     retired;
    logic   taken;

    dispatch_top #(
        .QDEPTH (QDEPTH)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid),
        .in_op_i      (in_op),
        .in_rd_i      (in_rd),
        .in_rs1_i     (in_rs1),
        .in_rs2_i     (in_rs2),
        .in_use_imm_i (in_use_imm),
        .in_imm_i     (in_imm),
        .in_ready_o   (in_ready),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    tb_checker #(
        .QDEPTH (QDEPTH)
    ) i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid),
        .in_op_i       (in_op),
        .in_rd_i       (in_rd),
        .in_rs1_i      (in_rs1),
        .in_rs2_i      (in_rs2),
        .in_use_imm_i  (in_use_imm),
        .in_imm_i      (in_imm),
        .in_ready_i    (in_ready),
        .wb_valid_i    (wb_valid),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .error_count_o (chk_errors),
        .retired_o     (retired)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Small register numbers keep hazards and forwarding frequent
    task automatic make_instr(int s);
        logic [31:0] r;
        r             = $random(seed);
        in_rd[s]      = {2'b00, r[2:0]};
        in_rs1[s]     = {2'b00, r[5:3]};
        in_rs2[s]     = {2'b00, r[8:6]};
        in_use_imm[s] = r[9];
        in_imm[s]     = $random(seed);
        if (r[12:10] == 3'd0) begin
            // About one in eight is a CSR access, addresses 4 and 5 do not exist
            in_op[s]              = r[13] ? OP_CSRWR : OP_CSRRD;
            in_imm[s][CSR_AW-1:0] = CSR_AW'(r[31:16] % 16'd6);
        end else begin
            in_op[s] = op_e'(4'(r[31:16] % 16'd6));
        end
    endtask

    task automatic offer_pair();
        logic [31:0] r;
        r        = $random(seed);
        in_valid = 2'b00;
        if (accepted < N_INSTR && r[1:0] != 2'b00) begin
            make_instr(0);
            in_valid[0] = 1'b1;
            if (r[1] && accepted + 1 < N_INSTR) begin
                make_instr(1);
                in_valid[1] = 1'b1;
            end
        end
    endtask

    initial begin
        seed       = 5;
        accepted   = 0;
        tb_errors  = 0;
        rst_n      = 1'b0;
        in_valid   = 2'b00;
        in_op[0]   = OP_ADD;
        in_op[1]   = OP_ADD;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_use_imm = '0;
        in_imm     = '0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // An offer is held until the queue takes it
        cycles = 0;
        while (accepted < N_INSTR && cycles < STIM_LIMIT) begin
            @(posedge clk);
            cycles++;
            taken = in_ready && in_valid[0];
            if (taken) begin
                accepted += in_valid[1] ? 2 : 1;
            end
            #10;
            if (taken || !in_valid[0]) begin
                offer_pair();
            end
        end
        in_valid = 2'b00;
        if (accepted < N_INSTR) begin
            tb_errors++;
            $display("stimulus timeout: only %0d of %0d instructions accepted",
                     accepted, N_INSTR);
        end

        cycles = 0;
        while (retired < accepted && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < accepted) begin
            tb_errors++;
            $display("drain timeout: %0d instructions still missing from writeback",
                     accepted - retired);
        end
        // A few idle cycles catch stray writebacks
        repeat (3) @(negedge clk);

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
common/slot_if.sv
hw/instr_queue.sv
dispatch/regfile.sv
dispatch/dispatch_stage.sv
hw/exec_unit.sv
hw/dispatch_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module tb_top -f list.f -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
exit 1
